/* design/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// instruction field widths.
`define OP_CODE_BITS        6
`define NUM_REGISTERS_LOG2  5
`define MEM_OP_BITS         2

// stall and nop masks, one bit per pipeline register.
`define NUM_PIPE_MASKS      3

`define PIPE_REG_PC         3'b001
`define PIPE_REG_IF_ID      3'b010
`define PIPE_REG_ID_EX      3'b100

// register-use masks, one bit per instruction field.
`define REG_MASK_RD         3'b001
`define REG_MASK_RT         3'b010
`define REG_MASK_RS         3'b100

`endif

/* design/cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

  // top two bits give the class.
  typedef enum logic [`OP_CODE_BITS-1:0] {
    op_nop  = 6'b000000,
    op_add  = 6'b000001,
    op_sub  = 6'b000010,
    op_jr   = 6'b001111,  // sits in the alu class.
    op_addi = 6'b010000,
    op_subi = 6'b010001,
    op_lw   = 6'b100000,
    op_sw   = 6'b100001,
    op_la   = 6'b100010,
    op_sa   = 6'b100011,
    op_jmp  = 6'b110000,
    op_je   = 6'b110001
  } opcode_e;

  typedef enum logic [`MEM_OP_BITS-1:0] {
    mem_none  = 2'b00,
    mem_read  = 2'b01,
    mem_write = 2'b10
  } mem_op_e;

endpackage

/* design/reg_use_decoder.sv */
`timescale 1ns/100ps

`include "cpu_macros.svh"

module reg_use_decoder (
  input  cpu_pkg::opcode_e opcode,
  output logic [2:0]       src_mask,
  output logic [2:0]       dst_mask,
  output cpu_pkg::mem_op_e mem_op
);
  import cpu_pkg::*;

  always_comb begin
    src_mask = '0;
    dst_mask = '0;
    mem_op   = mem_none;
    casez (opcode)
      op_nop: begin
        src_mask = '0;
        dst_mask = '0;
      end
      op_jr: begin
        src_mask = `REG_MASK_RS;  // jump target only.
        dst_mask = '0;
      end
      6'b00????: begin
        src_mask = `REG_MASK_RS | `REG_MASK_RT;
        dst_mask = `REG_MASK_RD;
      end
      6'b01????: begin
        src_mask = `REG_MASK_RS;
        dst_mask = `REG_MASK_RT;
      end
      6'b10????: begin
        case (opcode)
          op_lw: begin
            src_mask = `REG_MASK_RS;  // base.
            dst_mask = `REG_MASK_RT;
            mem_op   = mem_read;
          end
          op_sw: begin
            src_mask = `REG_MASK_RS | `REG_MASK_RT;
            mem_op   = mem_write;
          end
          op_la:   dst_mask = `REG_MASK_RT;
          op_sa:   src_mask = `REG_MASK_RT;
          default: mem_op = mem_none;
        endcase
      end
      default: begin
        src_mask = '0;  // jumps, no register use.
        dst_mask = '0;
      end
    endcase
  end

endmodule

/* design/hazard_detection_unit.sv */
`timescale 1ns/100ps

`include "cpu_macros.svh"

module hazard_detection_unit (
  input  logic                           clk,
  input  cpu_pkg::mem_op_e               id_ex_mem_op,
  input  logic [`NUM_REGISTERS_LOG2-1:0] id_ex_rt,
  input  logic                           first,
  input  logic [`NUM_REGISTERS_LOG2-1:0] rs0,
  input  logic [`NUM_REGISTERS_LOG2-1:0] rt0,
  input  logic [`NUM_REGISTERS_LOG2-1:0] rd0,
  input  logic [`NUM_REGISTERS_LOG2-1:0] rs1,
  input  logic [`NUM_REGISTERS_LOG2-1:0] rt1,
  input  logic [`NUM_REGISTERS_LOG2-1:0] rd1,
  input  logic [2:0]                     src_mask0,
  input  logic [2:0]                     dst_mask0,
  input  logic [2:0]                     src_mask1,
  input  logic [2:0]                     dst_mask1,
  output logic [`NUM_PIPE_MASKS-1:0]     stall0,
  output logic [`NUM_PIPE_MASKS-1:0]     nop0,
  output logic [`NUM_PIPE_MASKS-1:0]     stall1,
  output logic [`NUM_PIPE_MASKS-1:0]     nop1,
  output logic                           clear0,
  output logic                           clear1
);
  import cpu_pkg::*;

  localparam logic [`NUM_PIPE_MASKS-1:0] stall_all =
    `PIPE_REG_PC | `PIPE_REG_IF_ID | `PIPE_REG_ID_EX;

  logic                           load_use;
  logic                           pair_dep;
  logic [2:0]                     src_young;
  logic [2:0]                     dst_old;
  logic [`NUM_REGISTERS_LOG2-1:0] rs_young;
  logic [`NUM_REGISTERS_LOG2-1:0] rt_young;
  logic [`NUM_REGISTERS_LOG2-1:0] rt_old;
  logic [`NUM_REGISTERS_LOG2-1:0] rd_old;

  // raw field compare, unused fields included.
  assign load_use = (id_ex_mem_op == mem_read) &&
                    (rs0 == id_ex_rt || rt0 == id_ex_rt ||
                     rs1 == id_ex_rt || rt1 == id_ex_rt);

  // first set means slot 1 is the older one.
  assign src_young = first ? src_mask0 : src_mask1;
  assign rs_young  = first ? rs0 : rs1;
  assign rt_young  = first ? rt0 : rt1;
  assign dst_old   = first ? dst_mask1 : dst_mask0;
  assign rt_old    = first ? rt1 : rt0;
  assign rd_old    = first ? rd1 : rd0;

  // src bits are rs,rt,rd from msb; dst holds one bit at most.
  always_comb begin
    casez ({src_young, dst_old})
      6'b11?_?1?: pair_dep = (rs_young == rt_old) || (rt_young == rt_old);
      6'b11?_??1: pair_dep = (rs_young == rd_old) || (rt_young == rd_old);
      6'b1??_?1?: pair_dep = (rs_young == rt_old);
      6'b1??_??1: pair_dep = (rs_young == rd_old);
      6'b?1?_?1?: pair_dep = (rt_young == rt_old);
      6'b?1?_??1: pair_dep = (rt_young == rd_old);
      default:    pair_dep = 1'b0;
    endcase
  end

  always_comb begin
    stall0 = '0;
    nop0   = '0;
    clear0 = 1'b0;
    stall1 = '0;
    nop1   = '0;
    clear1 = 1'b0;
    if (load_use) begin
      stall0 = stall_all;  // whole front end waits.
      nop0   = `PIPE_REG_ID_EX;
      stall1 = stall_all;
      nop1   = `PIPE_REG_ID_EX;
    end else if (pair_dep) begin
      if (first) begin
        stall0 = stall_all;
        nop0   = `PIPE_REG_ID_EX;
        stall1 = `PIPE_REG_PC;  // older issues, then drops out.
        clear1 = 1'b1;
      end else begin
        stall1 = stall_all;
        nop1   = `PIPE_REG_ID_EX;
        stall0 = `PIPE_REG_PC;
        clear0 = 1'b1;
      end
    end
  end

  // only the older slot of a pair may be cleared.
  assert property (@(posedge clk) !(clear0 && clear1))
    else $error("hazard unit cleared both slots");

endmodule

/* design/issue_pair_regs.sv */
`timescale 1ns/100ps

`include "cpu_macros.svh"

module issue_pair_regs (
  input  logic                           clk,
  input  logic                           rst,
  input  cpu_pkg::opcode_e               fetch_opcode0,
  input  cpu_pkg::opcode_e               fetch_opcode1,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rs0,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rt0,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rd0,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rs1,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rt1,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rd1,
  input  logic                           fetch_first,
  input  logic [`NUM_PIPE_MASKS-1:0]     stall0,
  input  logic [`NUM_PIPE_MASKS-1:0]     stall1,
  input  logic [`NUM_PIPE_MASKS-1:0]     nop0,
  input  logic [`NUM_PIPE_MASKS-1:0]     nop1,
  input  logic                           clear0,
  input  logic                           clear1,
  output cpu_pkg::opcode_e               if_id_opcode0,
  output cpu_pkg::opcode_e               if_id_opcode1,
  output logic [`NUM_REGISTERS_LOG2-1:0] if_id_rs0,
  output logic [`NUM_REGISTERS_LOG2-1:0] if_id_rt0,
  output logic [`NUM_REGISTERS_LOG2-1:0] if_id_rd0,
  output logic [`NUM_REGISTERS_LOG2-1:0] if_id_rs1,
  output logic [`NUM_REGISTERS_LOG2-1:0] if_id_rt1,
  output logic [`NUM_REGISTERS_LOG2-1:0] if_id_rd1,
  output logic                           if_id_first,
  output cpu_pkg::opcode_e               ex_opcode0,
  output cpu_pkg::opcode_e               ex_opcode1,
  output logic [`NUM_REGISTERS_LOG2-1:0] ex_rt0,
  output logic [`NUM_REGISTERS_LOG2-1:0] ex_rt1,
  output cpu_pkg::mem_op_e               id_ex_mem_op,
  output logic [`NUM_REGISTERS_LOG2-1:0] id_ex_rt
);
  import cpu_pkg::*;

  opcode_e                        fetch_op [2];
  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rs [2];
  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rt [2];
  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rd [2];
  opcode_e                        if_id_op [2];
  logic [`NUM_REGISTERS_LOG2-1:0] if_id_rs [2];
  logic [`NUM_REGISTERS_LOG2-1:0] if_id_rt [2];
  logic [`NUM_REGISTERS_LOG2-1:0] if_id_rd [2];
  opcode_e                        ex_op [2];
  logic [`NUM_REGISTERS_LOG2-1:0] ex_rt_q [2];
  logic [1:0]                     clear;
  logic [1:0]                     hold_if_id;
  logic [1:0]                     bubble;
  logic                           first_q;

  assign fetch_op = '{fetch_opcode0, fetch_opcode1};
  assign fetch_rs = '{fetch_rs0, fetch_rs1};
  assign fetch_rt = '{fetch_rt0, fetch_rt1};
  assign fetch_rd = '{fetch_rd0, fetch_rd1};

  assign clear      = {clear1, clear0};
  assign hold_if_id = {|(stall1 & `PIPE_REG_IF_ID), |(stall0 & `PIPE_REG_IF_ID)};
  assign bubble     = {|(nop1 & `PIPE_REG_ID_EX), |(nop0 & `PIPE_REG_ID_EX)};

  always_ff @(posedge clk) begin
    for (int k = 0; k < 2; k++) begin
      if (rst || clear[k]) begin
        if_id_op[k] <= op_nop;
        if_id_rs[k] <= '0;
        if_id_rt[k] <= '0;
        if_id_rd[k] <= '0;
      end else if (!hold_if_id[k]) begin
        if_id_op[k] <= fetch_op[k];
        if_id_rs[k] <= fetch_rs[k];
        if_id_rt[k] <= fetch_rt[k];
        if_id_rd[k] <= fetch_rd[k];
      end
      if (rst || bubble[k]) begin
        ex_op[k]   <= op_nop;  // held slot leaves a bubble.
        ex_rt_q[k] <= '0;
      end else begin
        ex_op[k]   <= if_id_op[k];
        ex_rt_q[k] <= if_id_rt[k];
      end
    end
  end

  // order of the pair stays with the held slot.
  always_ff @(posedge clk) begin
    if (rst) begin
      first_q <= 1'b0;
    end else if (!(|hold_if_id)) begin
      first_q <= fetch_first;
    end
  end

  // pending load, slot 1 wins.
  always_comb begin
    if (ex_op[1] == op_lw) begin
      id_ex_mem_op = mem_read;
      id_ex_rt     = ex_rt_q[1];
    end else if (ex_op[0] == op_lw) begin
      id_ex_mem_op = mem_read;
      id_ex_rt     = ex_rt_q[0];
    end else begin
      id_ex_mem_op = mem_none;
      id_ex_rt     = '0;
    end
  end

  assign if_id_opcode0 = if_id_op[0];
  assign if_id_opcode1 = if_id_op[1];
  assign if_id_rs0     = if_id_rs[0];
  assign if_id_rt0     = if_id_rt[0];
  assign if_id_rd0     = if_id_rd[0];
  assign if_id_rs1     = if_id_rs[1];
  assign if_id_rt1     = if_id_rt[1];
  assign if_id_rd1     = if_id_rd[1];
  assign if_id_first   = first_q;
  assign ex_opcode0    = ex_op[0];
  assign ex_opcode1    = ex_op[1];
  assign ex_rt0        = ex_rt_q[0];
  assign ex_rt1        = ex_rt_q[1];

  // a cleared slot must not also be told to hold.
  assert property (@(posedge clk) disable iff (rst) !(|(clear & hold_if_id)))
    else $error("slot cleared and held in IF/ID at once");

endmodule

/* design/issue_control_top.sv */
`timescale 1ns/100ps

`include "cpu_macros.svh"

module issue_control_top (
  input  logic                           clk,
  input  logic                           rst,
  input  cpu_pkg::opcode_e               fetch_opcode0,
  input  cpu_pkg::opcode_e               fetch_opcode1,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rs0,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rt0,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rd0,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rs1,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rt1,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rd1,
  input  logic                           fetch_first,
  output logic                           fetch_ready,
  output logic [`NUM_PIPE_MASKS-1:0]     stall0,
  output logic [`NUM_PIPE_MASKS-1:0]     stall1,
  output logic [`NUM_PIPE_MASKS-1:0]     nop0,
  output logic [`NUM_PIPE_MASKS-1:0]     nop1,
  output logic                           clear0,
  output logic                           clear1,
  output cpu_pkg::opcode_e               ex_opcode0,
  output cpu_pkg::opcode_e               ex_opcode1,
  output logic [`NUM_REGISTERS_LOG2-1:0] ex_rt0,
  output logic [`NUM_REGISTERS_LOG2-1:0] ex_rt1
);
  import cpu_pkg::*;

  opcode_e                        if_id_opcode0;
  opcode_e                        if_id_opcode1;
  logic [`NUM_REGISTERS_LOG2-1:0] if_id_rs0;
  logic [`NUM_REGISTERS_LOG2-1:0] if_id_rt0;
  logic [`NUM_REGISTERS_LOG2-1:0] if_id_rd0;
  logic [`NUM_REGISTERS_LOG2-1:0] if_id_rs1;
  logic [`NUM_REGISTERS_LOG2-1:0] if_id_rt1;
  logic [`NUM_REGISTERS_LOG2-1:0] if_id_rd1;
  logic                           if_id_first;
  logic [2:0]                     src_mask0;
  logic [2:0]                     dst_mask0;
  logic [2:0]                     src_mask1;
  logic [2:0]                     dst_mask1;
  mem_op_e                        dec_mem_op0;
  mem_op_e                        dec_mem_op1;
  mem_op_e                        id_ex_mem_op;
  logic [`NUM_REGISTERS_LOG2-1:0] id_ex_rt;

  assign fetch_ready = !(|((stall0 | stall1) & `PIPE_REG_PC));  // pc not held.

  issue_pair_regs u_regs (
    .clk           (clk),
    .rst           (rst),
    .fetch_opcode0 (fetch_opcode0),
    .fetch_opcode1 (fetch_opcode1),
    .fetch_rs0     (fetch_rs0),
    .fetch_rt0     (fetch_rt0),
    .fetch_rd0     (fetch_rd0),
    .fetch_rs1     (fetch_rs1),
    .fetch_rt1     (fetch_rt1),
    .fetch_rd1     (fetch_rd1),
    .fetch_first   (fetch_first),
    .stall0        (stall0),
    .stall1        (stall1),
    .nop0          (nop0),
    .nop1          (nop1),
    .clear0        (clear0),
    .clear1        (clear1),
    .if_id_opcode0 (if_id_opcode0),
    .if_id_opcode1 (if_id_opcode1),
    .if_id_rs0     (if_id_rs0),
    .if_id_rt0     (if_id_rt0),
    .if_id_rd0     (if_id_rd0),
    .if_id_rs1     (if_id_rs1),
    .if_id_rt1     (if_id_rt1),
    .if_id_rd1     (if_id_rd1),
    .if_id_first   (if_id_first),
    .ex_opcode0    (ex_opcode0),
    .ex_opcode1    (ex_opcode1),
    .ex_rt0        (ex_rt0),
    .ex_rt1        (ex_rt1),
    .id_ex_mem_op  (id_ex_mem_op),
    .id_ex_rt      (id_ex_rt)
  );

  reg_use_decoder u_dec0 (
    .opcode   (if_id_opcode0),
    .src_mask (src_mask0),
    .dst_mask (dst_mask0),
    .mem_op   (dec_mem_op0)
  );

  reg_use_decoder u_dec1 (
    .opcode   (if_id_opcode1),
    .src_mask (src_mask1),
    .dst_mask (dst_mask1),
    .mem_op   (dec_mem_op1)
  );

  hazard_detection_unit u_hazard (
    .clk          (clk),
    .id_ex_mem_op (id_ex_mem_op),
    .id_ex_rt     (id_ex_rt),
    .first        (if_id_first),
    .rs0          (if_id_rs0),
    .rt0          (if_id_rt0),
    .rd0          (if_id_rd0),
    .rs1          (if_id_rs1),
    .rt1          (if_id_rt1),
    .rd1          (if_id_rd1),
    .src_mask0    (src_mask0),
    .dst_mask0    (dst_mask0),
    .src_mask1    (src_mask1),
    .dst_mask1    (dst_mask1),
    .stall0       (stall0),
    .nop0         (nop0),
    .stall1       (stall1),
    .nop1         (nop1),
    .clear0       (clear0),
    .clear1       (clear1)
  );

  // a decoded load that is not bubbled shows up as the pending load.
  assert property (@(posedge clk) disable iff (rst)
    ((dec_mem_op0 == mem_read && !(|(nop0 & `PIPE_REG_ID_EX))) ||
     (dec_mem_op1 == mem_read && !(|(nop1 & `PIPE_REG_ID_EX))))
    |=> id_ex_mem_op == mem_read)
    else $error("issued load missing from ID/EX");

endmodule

/* sim/issue_control_checker.sv */
`timescale 1ns/100ps

`include "cpu_macros.svh"

module issue_control_checker (
  input  logic                           clk,
  input  logic                           rst,
  input  cpu_pkg::opcode_e               fetch_opcode0,
  input  cpu_pkg::opcode_e               fetch_opcode1,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rs0,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rt0,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rd0,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rs1,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rt1,
  input  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rd1,
  input  logic                           fetch_first,
  input  logic                           fetch_ready,
  input  logic [`NUM_PIPE_MASKS-1:0]     stall0,
  input  logic [`NUM_PIPE_MASKS-1:0]     stall1,
  input  logic [`NUM_PIPE_MASKS-1:0]     nop0,
  input  logic [`NUM_PIPE_MASKS-1:0]     nop1,
  input  logic                           clear0,
  input  logic                           clear1,
  input  cpu_pkg::opcode_e               ex_opcode0,
  input  cpu_pkg::opcode_e               ex_opcode1,
  input  logic [`NUM_REGISTERS_LOG2-1:0] ex_rt0,
  input  logic [`NUM_REGISTERS_LOG2-1:0] ex_rt1,
  output int                             mismatch_count,
  output int                             load_use_count,
  output int                             pair_count
);
  import cpu_pkg::*;

  localparam logic [`NUM_PIPE_MASKS-1:0] stall_all =
    `PIPE_REG_PC | `PIPE_REG_IF_ID | `PIPE_REG_ID_EX;

  opcode_e                        m_if_op [2];
  logic [`NUM_REGISTERS_LOG2-1:0] m_if_rs [2];
  logic [`NUM_REGISTERS_LOG2-1:0] m_if_rt [2];
  logic [`NUM_REGISTERS_LOG2-1:0] m_if_rd [2];
  logic                           m_first;
  opcode_e                        m_ex_op [2];
  logic [`NUM_REGISTERS_LOG2-1:0] m_ex_rt [2];
  logic                           model_valid = 1'b0;
  int                             mismatches = 0;
  int                             load_uses = 0;
  int                             pair_splits = 0;
  logic                           load_pending;
  logic [`NUM_REGISTERS_LOG2-1:0] load_rt;
  logic [13:0]                    expected;
  logic [`NUM_PIPE_MASKS-1:0]     e_stall0;
  logic [`NUM_PIPE_MASKS-1:0]     e_nop0;
  logic [`NUM_PIPE_MASKS-1:0]     e_stall1;
  logic [`NUM_PIPE_MASKS-1:0]     e_nop1;
  logic                           e_clear0;
  logic                           e_clear1;
  logic                           e_ready;

  assign mismatch_count = mismatches;
  assign load_use_count = load_uses;
  assign pair_count     = pair_splits;

  // {reads rs, reads rt, writes rt, writes rd}.
  function automatic logic [3:0] field_use(input opcode_e op);
    case (op)
      op_add, op_sub:          field_use = 4'b1101;
      op_jr:                   field_use = 4'b1000;
      op_addi, op_subi, op_lw: field_use = 4'b1010;
      op_sw:                   field_use = 4'b1100;
      op_la:                   field_use = 4'b0010;
      op_sa:                   field_use = 4'b0100;
      default:                 field_use = 4'b0000;  // nop and jumps.
    endcase
  endfunction

  // returns {stall0, nop0, stall1, nop1, clear0, clear1}.
  function automatic logic [13:0] predict_hazard(
    input opcode_e op0, input logic [4:0] rs0, rt0, rd0,
    input opcode_e op1, input logic [4:0] rs1, rt1, rd1,
    input logic first, input logic pending, input logic [4:0] ld_rt
  );
    logic [3:0] use_old;
    logic [3:0] use_young;
    logic [4:0] rs_y;
    logic [4:0] rt_y;
    logic [4:0] wr;
    logic       dep;
    logic [2:0] s0;
    logic [2:0] n0;
    logic [2:0] s1;
    logic [2:0] n1;
    logic       c0;
    logic       c1;
    {s0, n0, s1, n1, c0, c1} = '0;
    if (pending && (rs0 == ld_rt || rt0 == ld_rt || rs1 == ld_rt || rt1 == ld_rt)) begin
      s0 = stall_all;
      n0 = `PIPE_REG_ID_EX;
      s1 = stall_all;
      n1 = `PIPE_REG_ID_EX;
    end else begin
      use_old   = first ? field_use(op1) : field_use(op0);
      use_young = first ? field_use(op0) : field_use(op1);
      rs_y = first ? rs0 : rs1;
      rt_y = first ? rt0 : rt1;
      if (first) wr = use_old[0] ? rd1 : rt1;
      else       wr = use_old[0] ? rd0 : rt0;
      dep = (use_old[1] || use_old[0]) &&
            ((use_young[3] && rs_y == wr) || (use_young[2] && rt_y == wr));
      if (dep && first) begin
        s0 = stall_all;
        n0 = `PIPE_REG_ID_EX;
        s1 = `PIPE_REG_PC;
        c1 = 1'b1;
      end else if (dep) begin
        s1 = stall_all;
        n1 = `PIPE_REG_ID_EX;
        s0 = `PIPE_REG_PC;
        c0 = 1'b1;
      end
    end
    predict_hazard = {s0, n0, s1, n1, c0, c1};
  endfunction

  task automatic compare(input string what, input logic [7:0] got, input logic [7:0] want);
    if (got !== want) begin
      mismatches++;
      $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, want);
    end
  endtask

  // ID/EX takes the old IF/ID, so it moves first.
  task automatic advance_slot(input logic k, input opcode_e op,
                              input logic [4:0] rs, rt, rd,
                              input logic [2:0] stall, nop, input logic clear);
    if (rst || (|(nop & `PIPE_REG_ID_EX))) begin
      m_ex_op[k] = op_nop;
      m_ex_rt[k] = '0;
    end else begin
      m_ex_op[k] = m_if_op[k];
      m_ex_rt[k] = m_if_rt[k];
    end
    if (rst || clear) begin
      m_if_op[k] = op_nop;
      m_if_rs[k] = '0;
      m_if_rt[k] = '0;
      m_if_rd[k] = '0;
    end else if (!(|(stall & `PIPE_REG_IF_ID))) begin
      m_if_op[k] = op;
      m_if_rs[k] = rs;
      m_if_rt[k] = rt;
      m_if_rd[k] = rd;
    end
  endtask

  // mid-cycle, registers and inputs are both settled.
  always @(negedge clk) begin
    load_pending = (m_ex_op[1] == op_lw) || (m_ex_op[0] == op_lw);
    load_rt      = (m_ex_op[1] == op_lw) ? m_ex_rt[1] : m_ex_rt[0];
    expected = predict_hazard(m_if_op[0], m_if_rs[0], m_if_rt[0], m_if_rd[0],
                              m_if_op[1], m_if_rs[1], m_if_rt[1], m_if_rd[1],
                              m_first, load_pending, load_rt);
    {e_stall0, e_nop0, e_stall1, e_nop1, e_clear0, e_clear1} = expected;
    e_ready = !(e_stall0[0] || e_stall1[0]);  // pc bit.
    if (model_valid) begin
      compare("stall0", 8'(stall0), 8'(e_stall0));
      compare("stall1", 8'(stall1), 8'(e_stall1));
      compare("nop0", 8'(nop0), 8'(e_nop0));
      compare("nop1", 8'(nop1), 8'(e_nop1));
      compare("clear0", 8'(clear0), 8'(e_clear0));
      compare("clear1", 8'(clear1), 8'(e_clear1));
      compare("fetch_ready", 8'(fetch_ready), 8'(e_ready));
      compare("ex_opcode0", 8'(ex_opcode0), 8'(m_ex_op[0]));
      compare("ex_opcode1", 8'(ex_opcode1), 8'(m_ex_op[1]));
      compare("ex_rt0", 8'(ex_rt0), 8'(m_ex_rt[0]));
      compare("ex_rt1", 8'(ex_rt1), 8'(m_ex_rt[1]));
      if (e_stall0 == stall_all && e_stall1 == stall_all) load_uses++;
      else if (e_clear0 || e_clear1) pair_splits++;
    end
    advance_slot(1'b0, fetch_opcode0, fetch_rs0, fetch_rt0, fetch_rd0,
                 e_stall0, e_nop0, e_clear0);
    advance_slot(1'b1, fetch_opcode1, fetch_rs1, fetch_rt1, fetch_rd1,
                 e_stall1, e_nop1, e_clear1);
    if (rst) m_first = 1'b0;
    else if (!(|((e_stall0 | e_stall1) & `PIPE_REG_IF_ID))) m_first = fetch_first;
    if (rst) model_valid = 1'b1;  // dut is reset at the next edge.
  end

endmodule

/* sim/issue_control_tb.sv */
`timescale 1ns/100ps

`include "cpu_macros.svh"

module issue_control_tb;
  import cpu_pkg::*;

  localparam time clk_half        = 50;
  localparam time drive_delay     = 1;
  localparam int  num_directed    = 8;
  localparam int  num_random      = 400;
  localparam int  watchdog_cycles = (num_directed + num_random) * 4 + 50;

  logic                           clk = 1'b0;
  logic                           rst;
  opcode_e                        fetch_opcode0;
  opcode_e                        fetch_opcode1;
  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rs0;
  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rt0;
  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rd0;
  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rs1;
  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rt1;
  logic [`NUM_REGISTERS_LOG2-1:0] fetch_rd1;
  logic                           fetch_first;
  logic                           fetch_ready;
  logic [`NUM_PIPE_MASKS-1:0]     stall0;
  logic [`NUM_PIPE_MASKS-1:0]     stall1;
  logic [`NUM_PIPE_MASKS-1:0]     nop0;
  logic [`NUM_PIPE_MASKS-1:0]     nop1;
  logic                           clear0;
  logic                           clear1;
  opcode_e                        ex_opcode0;
  opcode_e                        ex_opcode1;
  logic [`NUM_REGISTERS_LOG2-1:0] ex_rt0;
  logic [`NUM_REGISTERS_LOG2-1:0] ex_rt1;
  int                             mismatch_count;
  int                             load_use_count;
  int                             pair_count;
  int                             other_errors;
  integer                         seed;

  always #(clk_half) clk = ~clk;

  issue_control_top u_dut (.*);

  issue_control_checker u_chk (.*);

  task automatic next_edge();
    @(posedge clk);
    #(drive_delay);
  endtask

  // holds the pair until fetch_ready lets it in.
  task automatic send_pair(input opcode_e op0, input logic [4:0] rs0, rt0, rd0,
                           input opcode_e op1, input logic [4:0] rs1, rt1, rd1,
                           input logic first);
    logic taken;
    fetch_opcode0 = op0;
    fetch_rs0     = rs0;
    fetch_rt0     = rt0;
    fetch_rd0     = rd0;
    fetch_opcode1 = op1;
    fetch_rs1     = rs1;
    fetch_rt1     = rt1;
    fetch_rd1     = rd1;
    fetch_first   = first;
    taken = 1'b0;
    while (!taken) begin
      taken = fetch_ready;  // level for the coming edge.
      next_edge();
    end
  endtask

  function automatic opcode_e pick_opcode();
    logic [31:0] r;
    r = $random(seed);
    case (r % 12)
      0:       pick_opcode = op_nop;
      1:       pick_opcode = op_add;
      2:       pick_opcode = op_sub;
      3:       pick_opcode = op_jr;
      4:       pick_opcode = op_addi;
      5:       pick_opcode = op_subi;
      6:       pick_opcode = op_lw;
      7:       pick_opcode = op_sw;
      8:       pick_opcode = op_la;
      9:       pick_opcode = op_sa;
      10:      pick_opcode = op_jmp;
      default: pick_opcode = op_je;
    endcase
  endfunction

  // four registers only, so hazards come often.
  function automatic logic [4:0] pick_reg();
    logic [31:0] r;
    r = $random(seed);
    pick_reg = {3'b000, r[1:0]};
  endfunction

  function automatic logic pick_first();
    logic [31:0] r;
    r = $random(seed);
    pick_first = r[0];
  endfunction

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: stimulus did not finish within %0d cycles", watchdog_cycles);
    $display("errors: %0d mismatches, %0d other", mismatch_count, other_errors + 1);
    $display("Regression failed");
    $finish;
  end

  initial begin
    seed          = 32'h36272146;
    other_errors  = 0;
    rst           = 1'b1;
    fetch_opcode0 = op_nop;
    fetch_opcode1 = op_nop;
    fetch_rs0     = '0;
    fetch_rt0     = '0;
    fetch_rd0     = '0;
    fetch_rs1     = '0;
    fetch_rt1     = '0;
    fetch_rd1     = '0;
    fetch_first   = 1'b0;
    repeat (5) @(posedge clk);
    #(drive_delay);
    rst = 1'b0;

    // load in slot 1, then a reader of r5.
    send_pair(op_add, 5'd1, 5'd2, 5'd3, op_lw, 5'd4, 5'd5, 5'd0, 1'b1);
    send_pair(op_add, 5'd5, 5'd6, 5'd7, op_add, 5'd8, 5'd9, 5'd10, 1'b1);
    send_pair(op_sub, 5'd3, 5'd4, 5'd6, op_add, 5'd1, 5'd2, 5'd3, 1'b1);
    send_pair(op_add, 5'd1, 5'd2, 5'd7, op_add, 5'd7, 5'd2, 5'd8, 1'b0);
    send_pair(op_add, 5'd1, 5'd2, 5'd3, op_sub, 5'd4, 5'd5, 5'd6, 1'b1);
    send_pair(op_sw, 5'd2, 5'd3, 5'd0, op_sw, 5'd3, 5'd2, 5'd0, 1'b1);
    send_pair(op_jmp, 5'd1, 5'd1, 5'd1, op_je, 5'd1, 5'd1, 5'd1, 1'b0);
    send_pair(op_la, 5'd0, 5'd5, 5'd0, op_sa, 5'd0, 5'd5, 5'd0, 1'b1);

    for (int i = 0; i < num_random; i++) begin
      send_pair(pick_opcode(), pick_reg(), pick_reg(), pick_reg(),
                pick_opcode(), pick_reg(), pick_reg(), pick_reg(), pick_first());
    end

    // flush the last pairs through ID/EX.
    repeat (3) send_pair(op_nop, '0, '0, '0, op_nop, '0, '0, '0, 1'b0);
    next_edge();

    if (load_use_count == 0) begin
      $display("no load-use stall was seen during the run");
      other_errors++;
    end
    if (pair_count < 2) begin
      $display("fewer than two intra-pair splits were seen during the run");
      other_errors++;
    end
    $display("errors: %0d mismatches, %0d other", mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+design
design/cpu_pkg.sv
design/reg_use_decoder.sv
design/hazard_detection_unit.sv
design/issue_pair_regs.sv
design/issue_control_top.sv
sim/issue_control_checker.sv
sim/issue_control_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := issue_control_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
